// File: Makefile
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP ?= tb_tmu_pix
FILELIST ?= files.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: burst/tmu_burst.sv
/* Burst assembler */
`default_nettype none

module tmu_burst (
	input  logic            sys_clk,
	input  logic            sys_rst,
	input  logic            flush_i,
	input  logic            pipe_stb_i,
	output logic            pipe_ack_o,
	input  tmu_pkg::pixel_t pix_i,
	output logic            pipe_stb_o,
	input  logic            pipe_ack_i,
	output tmu_pkg::burst_t burst_o,
	output logic            busy_o
);
	import tmu_pkg::*;

	logic [BADR_W-1:0]          buf_addr;
	logic [BURST_PIX-1:0]       buf_sel;
	logic [255:0]               buf_data;
	logic                       flush_pend;
	logic                       flush_req;
	logic                       empty;
	logic                       mismatch;
	logic                       out_free;
	logic                       emit;
	logic                       write;
	logic [BADR_W-1:0]          pix_addr;
	logic [DADR_W-BADR_W-1:0]   pix_idx;
	logic [BURST_PIX-1:0]       pix_sel;

	assign pix_addr = pix_i.dadr[DADR_W-1 -: BADR_W];
	assign pix_idx  = pix_i.dadr[DADR_W-BADR_W-1:0];
	assign pix_sel  = {1'b1, {(BURST_PIX-1){1'b0}}} >> pix_idx; // Pixel 0 is the MSB.

	// Every stored pixel sets a select bit, so no bits means no pixels.
	assign empty     = (buf_sel == '0);
	assign flush_req = flush_i | flush_pend;
	assign mismatch  = pipe_stb_i & ~empty & (pix_addr != buf_addr);
	assign out_free  = ~pipe_stb_o | pipe_ack_i;
	assign emit      = (mismatch | (flush_req & ~empty)) & out_free;

	// Stall the source while the old burst still has to leave.
	assign pipe_ack_o = ~mismatch & ~flush_req;
	assign write      = pipe_stb_i & pipe_ack_o;
	assign busy_o     = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			buf_sel    <= '0;
			flush_pend <= 1'b0;
		end else begin
			if (emit) begin
				pipe_stb_o <= 1'b1;
			end else if (pipe_ack_i) begin
				pipe_stb_o <= 1'b0;
			end

			if (emit) begin
				buf_sel <= '0;
			end else if (write) begin
				buf_sel <= buf_sel | pix_sel; // Repeats keep their bit.
			end

			flush_pend <= flush_req & ~empty & ~out_free; // Hold until output frees.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (emit) begin
			burst_o.addr <= buf_addr;
			burst_o.sel  <= buf_sel;
			burst_o.data <= buf_data;
		end
		if (write) begin
			buf_addr <= pix_addr;
			buf_data[(BURST_PIX-1-pix_idx)*16 +: 16] <= pix_i.colour; // Last write wins.
		end
	end

endmodule

`default_nettype wire

// File: common/tmu_pkg.sv
/* Pixel pipeline shared types */
`default_nettype none

package tmu_pkg;

	localparam int FML_DEPTH = 25;              // Byte address width on FML.
	localparam int DADR_W    = FML_DEPTH - 1;   // Pixel address in 16-bit words.
	localparam int BURST_PIX = 16;              // Pixels per burst.
	localparam int BADR_W    = DADR_W - 4;      // Burst address width.
	localparam int FML_BEATS = 4;               // 64-bit beats per burst.

	// RGB565 colour word.
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Textured pixel with its destination.
	typedef struct packed {
		rgb565_t           colour;
		logic [DADR_W-1:0] dadr;   // Word address in the framebuffer.
	} pixel_t;

	// Run configuration, stable while busy.
	typedef struct packed {
		logic [5:0] brightness;    // 0 to 63, 63 is unity.
		logic       chroma_key_en;
		rgb565_t    chroma_key;
	} pix_cfg_t;

	// Pixel k of a burst sits at sel[15-k] and in the 16 bits of data
	// starting at bit 255-16k, so beat 0 is data[255:192] and lane 0 is
	// the top halfword of each beat.
	typedef struct packed {
		logic [BADR_W-1:0]    addr;
		logic [BURST_PIX-1:0] sel;
		logic [255:0]         data;
	} burst_t;

endpackage

`default_nettype wire

// File: decay/tmu_decay.sv
/* Brightness decay and chroma key */
`default_nettype none

module tmu_decay (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  tmu_pkg::pix_cfg_t cfg_i,
	input  logic              pipe_stb_i,
	output logic              pipe_ack_o,
	input  tmu_pkg::pixel_t   pix_i,
	output logic              pipe_stb_o,
	input  logic              pipe_ack_i,
	output tmu_pkg::pixel_t   pix_o,
	output logic              busy_o
);
	import tmu_pkg::*;

	logic [6:0]  scale;
	logic [11:0] red_p;
	logic [12:0] green_p;
	logic [11:0] blue_p;
	logic        keyed;
	pixel_t      pix_d;

	// Brightness plus one, so 63 gives a gain of exactly one.
	always_comb begin
		scale   = {1'b0, cfg_i.brightness} + 7'd1;
		red_p   = pix_i.colour.red * scale;
		green_p = pix_i.colour.green * scale;
		blue_p  = pix_i.colour.blue * scale;
		keyed   = cfg_i.chroma_key_en && (pix_i.colour == cfg_i.chroma_key); // Unscaled colour.
		pix_d.colour.red   = red_p[10:6];   // Divide by 64.
		pix_d.colour.green = green_p[11:6];
		pix_d.colour.blue  = blue_p[10:6];
		pix_d.dadr         = pix_i.dadr;
	end

	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign busy_o     = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else if (pipe_ack_o) begin
			pipe_stb_o <= pipe_stb_i & ~keyed; // Keyed pixels vanish here.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_ack_o & pipe_stb_i) begin
			pix_o <= pix_d;
		end
	end

endmodule

`default_nettype wire

// File: files.f
common/tmu_pkg.sv
decay/tmu_decay.sv
burst/tmu_burst.sv
pixout/tmu_pixout.sv
rtl/tmu_ctl.sv
rtl/tmu_pix.sv
test/tb_clkgen.sv
test/tmu_pix_chk.sv
test/tb_tmu_pix.sv

// File: pixout/tmu_pixout.sv
/* FML burst writer */
`default_nettype none

module tmu_pixout (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic                          pipe_stb_i,
	output logic                          pipe_ack_o,
	input  tmu_pkg::burst_t               burst_i,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic                          fmlw_stb_o,
	input  logic                          fmlw_ack_i,
	output logic [7:0]                    fmlw_sel_o,
	output logic [63:0]                   fmlw_do_o,
	output logic                          busy_o
);
	import tmu_pkg::*;

	burst_t     burst_q;
	logic       beat_active;
	logic [1:0] beat_cnt;
	logic [3:0] beat_sel;

	assign pipe_ack_o = ~fmlw_stb_o & ~beat_active;
	assign busy_o     = fmlw_stb_o | beat_active;
	assign fmlw_adr_o = {burst_q.addr, 5'b00000}; // 32-byte aligned.

	// Beat 0 is shown while waiting so it is valid in the ack cycle.
	always_comb begin
		fmlw_do_o = burst_q.data[(FML_BEATS-1-beat_cnt)*64 +: 64];
		beat_sel  = burst_q.sel[(FML_BEATS-1-beat_cnt)*(BURST_PIX/FML_BEATS) +: 4];
		for (int l = 0; l < BURST_PIX/FML_BEATS; l++) begin
			fmlw_sel_o[2*l +: 2] = {2{beat_sel[l]}}; // Two bytes per pixel.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlw_stb_o  <= 1'b0;
			beat_active <= 1'b0;
			beat_cnt    <= 2'd0;
		end else begin
			if (pipe_stb_i & pipe_ack_o) begin
				fmlw_stb_o <= 1'b1;
			end else if (fmlw_ack_i) begin
				fmlw_stb_o <= 1'b0;
			end

			if (fmlw_stb_o & fmlw_ack_i) begin
				beat_active <= 1'b1;
				beat_cnt    <= 2'd1;
			end else if (beat_active) begin
				beat_cnt <= beat_cnt + 2'd1; // Wraps to 0 after beat 3.
				if (beat_cnt == 2'd3) begin
					beat_active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o) begin
			burst_q <= burst_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/tmu_ctl.sv
/* Run control FSM */
`default_nettype none

module tmu_ctl (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic start_i,
	input  logic src_busy_i,
	input  logic decay_busy_i,
	input  logic burst_busy_i,
	input  logic pixout_busy_i,
	output logic flush_o,
	output logic busy_o
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_PROCESS,
		FLUSH,
		WAIT_FLUSH
	} state_t;

	state_t state;
	state_t next_state;
	logic   pipeline_busy;

	assign pipeline_busy = src_busy_i | decay_busy_i | burst_busy_i | pixout_busy_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		busy_o     = 1'b1;
		flush_o    = 1'b0;
		case (state)
			IDLE: begin
				busy_o = 1'b0;
				if (start_i) next_state = WAIT_PROCESS;
			end
			WAIT_PROCESS: if (~pipeline_busy) next_state = FLUSH;
			FLUSH: begin
				flush_o    = 1'b1; // Push out the partial burst.
				next_state = WAIT_FLUSH;
			end
			WAIT_FLUSH: if (~pipeline_busy) next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/tmu_pix.sv
/* Pixel back end top */
`default_nettype none

module tmu_pix (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic                          start_i,
	input  logic                          src_busy_i,
	input  tmu_pkg::pix_cfg_t             cfg_i,
	input  logic                          pix_stb_i,
	output logic                          pix_ack_o,
	input  tmu_pkg::pixel_t               pix_i,
	output logic                          busy_o,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic                          fmlw_stb_o,
	input  logic                          fmlw_ack_i,
	output logic [7:0]                    fmlw_sel_o,
	output logic [63:0]                   fmlw_do_o
);
	import tmu_pkg::*;

	logic   decay_stb;
	logic   decay_ack;
	pixel_t decay_pix;
	logic   decay_busy;
	logic   burst_stb;
	logic   burst_ack;
	burst_t burst_data;
	logic   burst_busy;
	logic   pixout_busy;
	logic   flush;

	tmu_ctl ctl (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.start_i       (start_i),
		.src_busy_i    (src_busy_i),
		.decay_busy_i  (decay_busy),
		.burst_busy_i  (burst_busy),
		.pixout_busy_i (pixout_busy),
		.flush_o       (flush),
		.busy_o        (busy_o)
	);

	tmu_decay decay (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.cfg_i      (cfg_i),
		.pipe_stb_i (pix_stb_i),
		.pipe_ack_o (pix_ack_o),
		.pix_i      (pix_i),
		.pipe_stb_o (decay_stb),
		.pipe_ack_i (decay_ack),
		.pix_o      (decay_pix),
		.busy_o     (decay_busy)
	);

	tmu_burst burst (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.flush_i    (flush),
		.pipe_stb_i (decay_stb),
		.pipe_ack_o (decay_ack),
		.pix_i      (decay_pix),
		.pipe_stb_o (burst_stb),
		.pipe_ack_i (burst_ack),
		.burst_o    (burst_data),
		.busy_o     (burst_busy)
	);

	tmu_pixout pixout (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (burst_stb),
		.pipe_ack_o (burst_ack),
		.burst_i    (burst_data),
		.fmlw_adr_o (fmlw_adr_o),
		.fmlw_stb_o (fmlw_stb_o),
		.fmlw_ack_i (fmlw_ack_i),
		.fmlw_sel_o (fmlw_sel_o),
		.fmlw_do_o  (fmlw_do_o),
		.busy_o     (pixout_busy)
	);

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
/* Testbench clock and reset */
`default_nettype none

module tb_clkgen (
	output logic sys_clk_o,
	output logic sys_rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sys_clk_o = 1'b0;
		forever #5 sys_clk_o = ~sys_clk_o; // 10 ns period.
	end

	initial begin
		sys_rst_o <= 1'b1;
		repeat (10) @(posedge sys_clk_o);
		sys_rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: test/tb_tmu_pix.sv
/* Pixel back end testbench */
`default_nettype none

module tb_tmu_pix;
	timeunit 1ns;
	timeprecision 1ps;
	import tmu_pkg::*;

	localparam int TOTAL_PIX   = 104;                // All pixels of all tests.
	localparam int CYCLE_LIMIT = TOTAL_PIX * 20 + 200;

	logic                 sys_clk;
	logic                 sys_rst;
	logic                 start_i    = 1'b0;
	logic                 src_busy_i = 1'b0;
	pix_cfg_t             cfg_i      = '0;
	logic                 pix_stb_i  = 1'b0;
	logic                 pix_ack_o;
	pixel_t               pix_i      = '0;
	logic                 busy_o;
	logic [FML_DEPTH-1:0] fmlw_adr_o;
	logic                 fmlw_stb_o;
	logic                 fmlw_ack_i = 1'b0;
	logic [7:0]           fmlw_sel_o;
	logic [63:0]          fmlw_do_o;

	logic [15:0] pix_lfsr   = 16'd64243;
	logic [15:0] delay_lfsr = 16'd64243;
	logic        ack_zero   = 1'b0;      // Fixes the ack delay at zero.
	int          cycles     = 0;
	logic [1:0]  resp_phase = 2'd0;
	logic [1:0]  resp_wait  = 2'd0;
	logic [1:0]  resp_beat  = 2'd0;
	burst_t      resp_cur;
	pixel_t      send_q[$];
	burst_t      exp_q[$];
	burst_t      got_q[$];

	tb_clkgen clkgen (
		.sys_clk_o (sys_clk),
		.sys_rst_o (sys_rst)
	);

	tmu_pix dut (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.start_i    (start_i),
		.src_busy_i (src_busy_i),
		.cfg_i      (cfg_i),
		.pix_stb_i  (pix_stb_i),
		.pix_ack_o  (pix_ack_o),
		.pix_i      (pix_i),
		.busy_o     (busy_o),
		.fmlw_adr_o (fmlw_adr_o),
		.fmlw_stb_o (fmlw_stb_o),
		.fmlw_ack_i (fmlw_ack_i),
		.fmlw_sel_o (fmlw_sel_o),
		.fmlw_do_o  (fmlw_do_o)
	);

	// Galois LFSR, right shifting, taps 16,14,13,11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic lsb;
		lsb = s[0];
		s   = s >> 1;
		if (lsb) s = s ^ 16'hB400;
		return s;
	endfunction

	function automatic rgb565_t scale_colour(input rgb565_t c, input logic [5:0] b);
		rgb565_t r;
		r.red   = 5'((int'(c.red) * (int'(b) + 1)) >> 6);
		r.green = 6'((int'(c.green) * (int'(b) + 1)) >> 6);
		r.blue  = 5'((int'(c.blue) * (int'(b) + 1)) >> 6);
		return r;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_burst(input int n, input burst_t got, input burst_t exp);
		logic [255:0] mask;
		for (int k = 0; k < BURST_PIX; k++)
			mask[(BURST_PIX-1-k)*16 +: 16] = {16{exp.sel[BURST_PIX-1-k]}};
		if (got.addr !== exp.addr)
			stop_run($sformatf("error: fmlw_adr_o burst %0d got %h expected %h",
				n, {got.addr, 5'b0}, {exp.addr, 5'b0}));
		if (got.sel !== exp.sel)
			stop_run($sformatf("error: fmlw_sel_o burst %0d got %h expected %h",
				n, got.sel, exp.sel));
		if ((got.data & mask) !== (exp.data & mask))
			stop_run($sformatf("error: fmlw_do_o burst %0d got %h expected %h",
				n, got.data & mask, exp.data & mask));
	endtask

	task automatic draw_colour(output rgb565_t c);
		for (int j = 0; j < 16; j++) begin
			c[j]     = pix_lfsr[0];
			pix_lfsr = lfsr_next(pix_lfsr);
		end
	endtask

	// Reference packing: pixel k in beat k/4, lane k mod 4, lane 0 on top.
	task automatic build_expected(input pix_cfg_t cfg);
		burst_t cur;
		int     k;
		cur = '0;
		foreach (send_q[i]) begin
			if (!(cfg.chroma_key_en && send_q[i].colour == cfg.chroma_key)) begin
				if (cur.sel != '0 && send_q[i].dadr[DADR_W-1:4] != cur.addr) begin
					exp_q.push_back(cur);
					cur.sel = '0;
				end
				k = int'(send_q[i].dadr[3:0]);
				cur.addr = send_q[i].dadr[DADR_W-1:4];
				cur.sel[15-k] = 1'b1;
				cur.data[255 - 64*(k/4) - 16*(k%4) -: 16] =
					scale_colour(send_q[i].colour, cfg.brightness);
			end
		end
		if (cur.sel != '0) exp_q.push_back(cur);
	endtask

	task automatic run_pixels(input pix_cfg_t cfg);
		@(posedge sys_clk);
		cfg_i      <= cfg;
		src_busy_i <= 1'b1;
		start_i    <= 1'b1;
		@(posedge sys_clk);
		start_i <= 1'b0;
		foreach (send_q[i]) begin
			pix_i     <= send_q[i];
			pix_stb_i <= 1'b1;
			do @(posedge sys_clk); while (!pix_ack_o); // Taken at this edge.
		end
		pix_stb_i  <= 1'b0;
		src_busy_i <= 1'b0;
		do @(posedge sys_clk); while (busy_o);
	endtask

	task automatic run_and_check(input pix_cfg_t cfg);
		run_pixels(cfg);
		@(posedge sys_clk);
		check_flag("busy_o", busy_o, 1'b0);         // Stays idle until the next start.
		check_flag("fmlw_stb_o", fmlw_stb_o, 1'b0);
		build_expected(cfg);
		if (got_q.size() != exp_q.size())
			stop_run($sformatf("error: write count got %h expected %h",
				got_q.size(), exp_q.size()));
		foreach (exp_q[n]) check_burst(n, got_q[n], exp_q[n]);
		send_q.delete();
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic queue_pixels(input int count, input logic [DADR_W-1:0] base,
			input int wrap);
		pixel_t p;
		for (int i = 0; i < count; i++) begin
			draw_colour(p.colour);
			p.dadr = base + DADR_W'(i % wrap);
			send_q.push_back(p);
		end
	endtask

	task automatic test_reset;
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("fmlw_stb_o", fmlw_stb_o, 1'b0);
		check_flag("pix_ack_o", pix_ack_o, 1'b1);
	endtask

	task automatic test_full_burst;
		pix_cfg_t cfg;
		cfg = '{brightness: 6'd63, chroma_key_en: 1'b0, chroma_key: '0};
		ack_zero = 1'b1;
		queue_pixels(16, 24'h012340, 16);
		run_and_check(cfg);
	endtask

	task automatic test_brightness;
		pix_cfg_t cfg;
		cfg = '{brightness: 6'd31, chroma_key_en: 1'b0, chroma_key: '0};
		queue_pixels(16, 24'h023450, 16);
		run_and_check(cfg);
	endtask

	task automatic test_chroma_flush;
		pix_cfg_t cfg;
		cfg = '{brightness: 6'd63, chroma_key_en: 1'b1, chroma_key: 16'hF81F};
		queue_pixels(12, 24'h045670, 16); // Ends mid-burst.
		for (int i = 1; i < 12; i += 3) send_q[i].colour = cfg.chroma_key;
		run_and_check(cfg);
	endtask

	task automatic test_backpressure;
		pix_cfg_t cfg;
		cfg = '{brightness: 6'd50, chroma_key_en: 1'b0, chroma_key: '0};
		ack_zero = 1'b0;
		queue_pixels(40, 24'h0789A4, 40); // Indices 4..15, 16, then 0..11.
		run_and_check(cfg);
	endtask

	task automatic test_repeat_run;
		pix_cfg_t cfg;
		cfg = '{brightness: 6'd47, chroma_key_en: 1'b0, chroma_key: '0};
		queue_pixels(10, 24'h0ABC00, 10);
		run_and_check(cfg);
		queue_pixels(10, 24'h0ABC10, 8);  // Indices 0 and 1 repeat.
		cfg = '{brightness: 6'd15, chroma_key_en: 1'b1, chroma_key: send_q[3].colour};
		run_and_check(cfg);
	endtask

	// Memory side of the write port.
	always @(posedge sys_clk) begin
		logic [1:0] delay;
		int         b;
		if (sys_rst) begin
			fmlw_ack_i <= 1'b0;
			resp_phase <= 2'd0;
		end else begin
			case (resp_phase)
				2'd0: if (fmlw_stb_o) begin
					delay = 2'd0;
					if (!ack_zero) begin
						for (int j = 0; j < 2; j++) begin
							delay[j]   = delay_lfsr[0];
							delay_lfsr = lfsr_next(delay_lfsr);
						end
					end
					if (delay == 2'd0) begin
						fmlw_ack_i <= 1'b1;
						resp_phase <= 2'd2;
					end else begin
						resp_wait  <= delay - 2'd1;
						resp_phase <= 2'd1;
					end
				end
				2'd1: begin
					if (resp_wait == 2'd0) begin
						fmlw_ack_i <= 1'b1;
						resp_phase <= 2'd2;
					end else begin
						resp_wait <= resp_wait - 2'd1;
					end
				end
				default: begin
					if (resp_phase == 2'd2) begin
						if (!fmlw_stb_o) stop_run("ack given with no write strobe pending");
						if (fmlw_adr_o[4:0] != 5'd0)
							stop_run($sformatf("error: fmlw_adr_o got %h expected %h",
								fmlw_adr_o, {fmlw_adr_o[FML_DEPTH-1:5], 5'b0}));
						resp_cur.addr = fmlw_adr_o[FML_DEPTH-1:5];
						b = 0;
						fmlw_ack_i <= 1'b0;
					end else begin
						b = int'(resp_beat);
					end
					resp_cur.data[255 - 64*b -: 64] = fmlw_do_o;
					for (int l = 0; l < 4; l++) begin
						check_flag("fmlw_sel_o pair", fmlw_sel_o[6-2*l], fmlw_sel_o[7-2*l]);
						resp_cur.sel[15 - 4*b - l] = fmlw_sel_o[7-2*l];
					end
					resp_beat <= 2'(b + 1);
					if (b == 3) begin
						got_q.push_back(resp_cur);
						resp_phase <= 2'd0;
					end else begin
						resp_phase <= 2'd3;
					end
				end
			endcase
		end
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_run("timeout: the run did not end within the cycle limit");
		end
	end

	initial begin
		do @(posedge sys_clk); while (sys_rst);
		test_reset();
		test_full_burst();
		test_brightness();
		test_chroma_flush();
		test_backpressure();
		test_repeat_run();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tmu_pix_chk.sv
/* Write port and control checks */
`default_nettype none

module tmu_pix_chk (
	input logic                          sys_clk,
	input logic                          sys_rst,
	input logic                          busy_o,
	input logic                          fmlw_stb_o,
	input logic                          fmlw_ack_i,
	input logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	input logic                          flush
);
	timeunit 1ns;
	timeprecision 1ps;

	stb_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o && $stable(fmlw_adr_o))
		else $error("fmlw_stb_o or fmlw_adr_o changed before ack");

	stb_needs_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!busy_o |-> !fmlw_stb_o)
		else $error("fmlw_stb_o high while busy_o is low");

	flush_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush |=> !flush)
		else $error("flush pulse longer than one cycle");

endmodule

bind tmu_pix tmu_pix_chk chk (
	.sys_clk    (sys_clk),
	.sys_rst    (sys_rst),
	.busy_o     (busy_o),
	.fmlw_stb_o (fmlw_stb_o),
	.fmlw_ack_i (fmlw_ack_i),
	.fmlw_adr_o (fmlw_adr_o),
	.flush      (flush)
);

`default_nettype wire
